//--- hdl/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// Major opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		OpRType = 6'b000000,
		OpJ     = 6'b000010,
		OpBne   = 6'b000101,
		OpLi    = 6'b001001,
		OpXori  = 6'b001110,
		OpLw    = 6'b100011,
		OpSw    = 6'b101011
	} opcodeE;

	// R-type function code, bits 5:0
	typedef enum logic [5:0] {
		FuncAdd = 6'b100000,
		FuncSub = 6'b100010,
		FuncSlt = 6'b101010
	} funcE;

	// Operation picked in decode
	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluSlt,
		AluXor,
		AluPassImm
	} aluOpE;

	// Where an execute operand comes from
	typedef enum logic [1:0] {
		FwdReg,
		FwdMem,
		FwdWb
	} forwardSelE;

endpackage

//--- hdl/fetchStage.sv
`timescale 1ns/100ps

module fetchStage #(
	parameter int imemAddrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic progWrite,
	input  logic [imemAddrWidth-1:0] progAddr,
	input  cpuPkg::wordT progData,
	input  logic stall,
	input  logic jumpTaken,
	input  cpuPkg::wordT jumpTarget,
	input  logic branchTaken,
	input  cpuPkg::wordT branchTarget,
	output cpuPkg::wordT ifInstr,
	output cpuPkg::wordT ifPcNext,
	output logic ifValid
);

	cpuPkg::wordT instrMem [2**imemAddrWidth];
	cpuPkg::wordT pc;

	// Program load port
	always_ff @(posedge clk) begin
		if (progWrite) begin
			instrMem[progAddr] <= progData;
		end
	end

	// Branch wins over jump, both squash the word being fetched
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifValid <= 1'b0;
		end else if (branchTaken) begin
			pc <= branchTarget;
			ifValid <= 1'b0;
		end else if (jumpTaken) begin
			pc <= jumpTarget;
			ifValid <= 1'b0;
		end else if (!stall) begin
			if (run) begin
				pc <= pc + 32'd1;
			end
			ifValid <= run;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifInstr <= instrMem[pc[imemAddrWidth-1:0]];
			ifPcNext <= pc + 32'd1;
		end
	end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
	input  logic clk,
	input  logic reset,
	input  cpuPkg::wordT ifInstr,
	input  cpuPkg::wordT ifPcNext,
	input  logic ifValid,
	input  logic stall,
	input  logic branchTaken,
	input  logic wbValid,
	input  cpuPkg::regAddrT wbReg,
	input  cpuPkg::wordT wbData,
	output logic jumpTaken,
	output cpuPkg::wordT jumpTarget,
	output logic idValid,
	output cpuPkg::aluOpE idAluOp,
	output cpuPkg::regAddrT idSrcA,
	output cpuPkg::regAddrT idSrcB,
	output cpuPkg::wordT idRegA,
	output cpuPkg::wordT idRegB,
	output cpuPkg::wordT idImm,
	output logic idBranch,
	output cpuPkg::wordT idBranchTarget,
	output logic idMemRead,
	output logic idMemWrite,
	output logic idRegWrite,
	output cpuPkg::regAddrT idDest
);

	cpuPkg::wordT regFile [32];
	cpuPkg::opcodeE opcode;
	cpuPkg::funcE func;
	cpuPkg::regAddrT rs;
	cpuPkg::regAddrT rt;
	cpuPkg::regAddrT rd;
	cpuPkg::wordT imm;
	cpuPkg::wordT readA;
	cpuPkg::wordT readB;
	cpuPkg::aluOpE aluOp;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic branch;
	logic useRd;

	assign opcode = cpuPkg::opcodeE'(ifInstr[31:26]);
	assign func = cpuPkg::funcE'(ifInstr[5:0]);
	assign rs = ifInstr[25:21];
	assign rt = ifInstr[20:16];
	assign rd = ifInstr[15:11];
	assign imm = {{16{ifInstr[15]}}, ifInstr[15:0]};

	always_ff @(posedge clk) begin
		if (wbValid && wbReg != '0) begin
			regFile[wbReg] <= wbData;
		end
	end

	// Register 0 reads zero, a same-cycle writeback bypasses the array
	assign readA = (rs == '0) ? '0 : (wbValid && wbReg == rs) ? wbData : regFile[rs];
	assign readB = (rt == '0) ? '0 : (wbValid && wbReg == rt) ? wbData : regFile[rt];

	always_comb begin
		aluOp = cpuPkg::AluAdd;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		useRd = 1'b0;
		case (opcode)
			cpuPkg::OpRType: begin
				useRd = 1'b1;
				regWrite = func inside {cpuPkg::FuncAdd, cpuPkg::FuncSub, cpuPkg::FuncSlt};
				if (func == cpuPkg::FuncSub) begin
					aluOp = cpuPkg::AluSub;
				end else if (func == cpuPkg::FuncSlt) begin
					aluOp = cpuPkg::AluSlt;
				end
			end
			cpuPkg::OpLi: begin
				aluOp = cpuPkg::AluPassImm;
				regWrite = 1'b1;
			end
			cpuPkg::OpXori: begin
				aluOp = cpuPkg::AluXor;
				regWrite = 1'b1;
			end
			cpuPkg::OpLw: begin
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::OpSw: memWrite = 1'b1;
			cpuPkg::OpBne: branch = 1'b1;
			default: aluOp = cpuPkg::AluAdd;
		endcase
	end

	// J resolves here
	assign jumpTaken = ifValid && opcode == cpuPkg::OpJ;
	assign jumpTarget = {ifPcNext[31:26], ifInstr[25:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			idValid <= 1'b0;
			idBranch <= 1'b0;
			idMemRead <= 1'b0;
			idMemWrite <= 1'b0;
			idRegWrite <= 1'b0;
		end else begin
			// Bubble on a stall or a taken branch
			idValid <= ifValid && !stall && !branchTaken;
			idBranch <= branch;
			idMemRead <= memRead;
			idMemWrite <= memWrite;
			idRegWrite <= regWrite;
		end
	end

	always_ff @(posedge clk) begin
		idAluOp <= aluOp;
		idSrcA <= rs;
		idSrcB <= rt;
		idRegA <= readA;
		idRegB <= readB;
		idImm <= imm;
		idBranchTarget <= ifPcNext + imm;
		idDest <= useRd ? rd : rt;
	end

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input  cpuPkg::regAddrT idSrcA,
	input  cpuPkg::regAddrT idSrcB,
	input  logic idValid,
	input  logic idMemRead,
	input  cpuPkg::regAddrT idDest,
	input  cpuPkg::wordT ifInstr,
	input  logic ifValid,
	input  logic exValid,
	input  logic exRegWrite,
	input  cpuPkg::regAddrT exDest,
	input  logic wbValid,
	input  cpuPkg::regAddrT wbReg,
	output logic stall,
	output cpuPkg::forwardSelE forwardA,
	output cpuPkg::forwardSelE forwardB
);

	cpuPkg::opcodeE ifOpcode;
	logic usesRs;
	logic usesRt;

	function automatic cpuPkg::forwardSelE pickSource(
		input cpuPkg::regAddrT src,
		input logic exWrites,
		input cpuPkg::regAddrT exReg,
		input logic wbWrites,
		input cpuPkg::regAddrT wbAddr
	);
		// Youngest result first
		if (src == '0) begin
			return cpuPkg::FwdReg;
		end else if (exWrites && exReg == src) begin
			return cpuPkg::FwdMem;
		end else if (wbWrites && wbAddr == src) begin
			return cpuPkg::FwdWb;
		end
		return cpuPkg::FwdReg;
	endfunction

	assign ifOpcode = cpuPkg::opcodeE'(ifInstr[31:26]);
	assign usesRs = ifOpcode inside {cpuPkg::OpRType, cpuPkg::OpBne, cpuPkg::OpSw,
		cpuPkg::OpXori, cpuPkg::OpLw};
	assign usesRt = ifOpcode inside {cpuPkg::OpRType, cpuPkg::OpBne, cpuPkg::OpSw};

	// Load in ID/EX feeding the instruction in IF/ID
	assign stall = ifValid && idValid && idMemRead && idDest != '0 &&
		((usesRs && ifInstr[25:21] == idDest) || (usesRt && ifInstr[20:16] == idDest));

	assign forwardA = pickSource(idSrcA, exValid && exRegWrite, exDest, wbValid, wbReg);
	assign forwardB = pickSource(idSrcB, exValid && exRegWrite, exDest, wbValid, wbReg);

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/100ps

module executeStage (
	input  logic clk,
	input  logic reset,
	input  logic idValid,
	input  cpuPkg::aluOpE idAluOp,
	input  cpuPkg::wordT idRegA,
	input  cpuPkg::wordT idRegB,
	input  cpuPkg::wordT idImm,
	input  logic idBranch,
	input  cpuPkg::wordT idBranchTarget,
	input  logic idMemRead,
	input  logic idMemWrite,
	input  logic idRegWrite,
	input  cpuPkg::regAddrT idDest,
	input  cpuPkg::forwardSelE forwardA,
	input  cpuPkg::forwardSelE forwardB,
	input  cpuPkg::wordT wbData,
	output logic branchTaken,
	output cpuPkg::wordT branchTarget,
	output logic exValid,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exRegWrite,
	output cpuPkg::regAddrT exDest,
	output cpuPkg::wordT exResult,
	output cpuPkg::wordT exStoreData
);

	cpuPkg::wordT opA;
	cpuPkg::wordT fwdB;
	cpuPkg::wordT opB;
	cpuPkg::wordT aluResult;
	logic useImm;

	function automatic cpuPkg::wordT selectOperand(
		input cpuPkg::forwardSelE sel,
		input cpuPkg::wordT regVal,
		input cpuPkg::wordT memVal,
		input cpuPkg::wordT wbVal
	);
		case (sel)
			cpuPkg::FwdMem: return memVal;
			cpuPkg::FwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = selectOperand(forwardA, idRegA, exResult, wbData);
	assign fwdB = selectOperand(forwardB, idRegB, exResult, wbData);

	// Address calculation and XORI use the immediate
	assign useImm = idMemRead || idMemWrite || idAluOp == cpuPkg::AluXor;
	assign opB = useImm ? idImm : fwdB;

	always_comb begin
		case (idAluOp)
			cpuPkg::AluAdd: aluResult = opA + opB;
			cpuPkg::AluSub: aluResult = opA - opB;
			cpuPkg::AluSlt: aluResult = (opA < opB) ? 32'd1 : 32'd0;
			cpuPkg::AluXor: aluResult = opA ^ opB;
			cpuPkg::AluPassImm: aluResult = idImm;
			default: aluResult = '0;
		endcase
	end

	assign branchTaken = idValid && idBranch && opA != fwdB;
	assign branchTarget = idBranchTarget;

	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
		end else begin
			exValid <= idValid && !branchTaken;
			exMemRead <= idMemRead;
			exMemWrite <= idMemWrite;
			exRegWrite <= idRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		exDest <= idDest;
		exResult <= aluResult;
		exStoreData <= fwdB;
	end

endmodule

//--- hdl/memoryStage.sv
`timescale 1ns/100ps

module memoryStage #(
	parameter int dmemAddrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic exValid,
	input  logic exMemRead,
	input  logic exMemWrite,
	input  logic exRegWrite,
	input  cpuPkg::regAddrT exDest,
	input  cpuPkg::wordT exResult,
	input  cpuPkg::wordT exStoreData,
	output logic storeValid,
	output logic [dmemAddrWidth-1:0] storeAddr,
	output cpuPkg::wordT storeData,
	output logic wbValid,
	output cpuPkg::regAddrT wbReg,
	output cpuPkg::wordT wbData
);

	cpuPkg::wordT dataMem [2**dmemAddrWidth];
	logic [dmemAddrWidth-1:0] memAddr;

	// Word address from the ALU
	assign memAddr = exResult[dmemAddrWidth-1:0];

	// Store port shows the write as it happens
	assign storeValid = exValid && exMemWrite;
	assign storeAddr = memAddr;
	assign storeData = exStoreData;

	always_ff @(posedge clk) begin
		if (storeValid) begin
			dataMem[memAddr] <= exStoreData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exValid && exRegWrite && exDest != '0;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= exDest;
		wbData <= exMemRead ? dataMem[memAddr] : exResult;
	end

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/100ps

module cpuTop #(
	parameter int imemAddrWidth = 8,
	parameter int dmemAddrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic progWrite,
	input  logic [imemAddrWidth-1:0] progAddr,
	input  cpuPkg::wordT progData,
	output logic wbValid,
	output cpuPkg::regAddrT wbReg,
	output cpuPkg::wordT wbData,
	output logic storeValid,
	output logic [dmemAddrWidth-1:0] storeAddr,
	output cpuPkg::wordT storeData
);

	cpuPkg::wordT ifInstr;
	cpuPkg::wordT ifPcNext;
	logic ifValid;
	logic jumpTaken;
	cpuPkg::wordT jumpTarget;
	logic branchTaken;
	cpuPkg::wordT branchTarget;
	logic stall;
	cpuPkg::forwardSelE forwardA;
	cpuPkg::forwardSelE forwardB;

	logic idValid;
	cpuPkg::aluOpE idAluOp;
	cpuPkg::regAddrT idSrcA;
	cpuPkg::regAddrT idSrcB;
	cpuPkg::wordT idRegA;
	cpuPkg::wordT idRegB;
	cpuPkg::wordT idImm;
	logic idBranch;
	cpuPkg::wordT idBranchTarget;
	logic idMemRead;
	logic idMemWrite;
	logic idRegWrite;
	cpuPkg::regAddrT idDest;

	logic exValid;
	logic exMemRead;
	logic exMemWrite;
	logic exRegWrite;
	cpuPkg::regAddrT exDest;
	cpuPkg::wordT exResult;
	cpuPkg::wordT exStoreData;

	fetchStage #(.imemAddrWidth(imemAddrWidth)) fetch (.*);

	decodeStage decode (.*);

	hazardUnit hazard (.*);

	executeStage execute (.*);

	memoryStage #(.dmemAddrWidth(dmemAddrWidth)) memory (
		.clk(clk),
		.reset(reset),
		.exValid(exValid),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exRegWrite(exRegWrite),
		.exDest(exDest),
		.exResult(exResult),
		.exStoreData(exStoreData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#2 reset = 1'b0;
	end

	// 40 ns period
	always #20 clk = ~clk;

endmodule

//--- testbench/cpuTop_properties.sv
`timescale 1ns/100ps

module cpuTopProperties (
	input logic clk,
	input logic reset,
	input logic wbValid,
	input cpuPkg::regAddrT wbReg,
	input logic storeValid,
	input logic stall,
	input logic branchTaken
);

	int violations = 0;

	// Sync reset clears both strobes one edge in
	resetClearsStrobes: assert property (@(posedge clk) reset |=> !wbValid && !storeValid)
		else begin
			$error("wbValid or storeValid high while reset is held");
			violations++;
		end

	stallSingleCycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
		else begin
			$error("stall held for two cycles in a row");
			violations++;
		end

	wbNeverRegZero: assert property (@(posedge clk) disable iff (reset)
		wbValid |-> wbReg != '0)
		else begin
			$error("writeback to register 0");
			violations++;
		end

	noBranchDuringStall: assert property (@(posedge clk) disable iff (reset)
		!(branchTaken && stall))
		else begin
			$error("branchTaken and stall high together");
			violations++;
		end

endmodule

bind cpuTop cpuTopProperties props (.*);

//--- testbench/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

	localparam int imemAddrWidth = 8;
	localparam int dmemAddrWidth = 8;
	localparam int quietCycles = 8;

	logic clk;
	logic porReset;
	logic tbReset;
	logic reset;
	logic run;
	logic progWrite;
	logic [imemAddrWidth-1:0] progAddr;
	cpuPkg::wordT progData;
	logic wbValid;
	cpuPkg::regAddrT wbReg;
	cpuPkg::wordT wbData;
	logic storeValid;
	logic [dmemAddrWidth-1:0] storeAddr;
	cpuPkg::wordT storeData;

	// Test table as read from the data file
	string testName[$];
	int progFirst[$];
	int progLen[$];
	int eventFirst[$];
	int eventLen[$];
	cpuPkg::wordT progWords[$];
	bit expIsStore[$];
	int expKey[$];
	cpuPkg::wordT expValue[$];

	int curTest;
	int nextEvent;
	int lastEvent;
	bit checking;
	int testErrors;
	int totalErrors;
	int failedTests;
	int checkCount;
	int cycleCount;
	int cycleLimit;

	assign reset = porReset || tbReset;

	clockGen clocks (.clk(clk), .reset(porReset));

	cpuTop #(.imemAddrWidth(imemAddrWidth), .dmemAddrWidth(dmemAddrWidth)) dut (.*);

	function automatic bit loadTable();
		int fd;
		int n;
		bit inProg;
		string tok;
		string a;
		string b;
		string rest;
		fd = $fopen("testbench/program_input.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		inProg = 1'b0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
			end else if (tok == "test") begin
				n = $fscanf(fd, "%s", a);
				testName.push_back(a);
				progFirst.push_back(progWords.size());
				progLen.push_back(0);
				eventFirst.push_back(expKey.size());
				eventLen.push_back(0);
				inProg = 1'b0;
			end else if (tok == "prog") begin
				inProg = 1'b1;
			end else if (tok == "wb" || tok == "store") begin
				n = $fscanf(fd, "%s %s", a, b);
				expIsStore.push_back(tok == "store");
				expKey.push_back((tok == "store") ? a.atohex() : a.atoi());
				expValue.push_back(b.atohex());
				eventLen[eventLen.size()-1] += 1;
				inProg = 1'b0;
			end else if (tok == "end") begin
				inProg = 1'b0;
			end else if (inProg) begin
				progWords.push_back(tok.atohex());
				progLen[progLen.size()-1] += 1;
			end
		end
		$fclose(fd);
		return testName.size() > 0;
	endfunction

	task automatic compareEvent(input bit isStore, input int key, input cpuPkg::wordT value);
		string keyName;
		string valueName;
		keyName = isStore ? "storeAddr" : "wbReg";
		valueName = isStore ? "storeData" : "wbData";
		assert (nextEvent < lastEvent) else begin
			$display("%0t ns: test %s produced %s=%0h after its last expected event",
				$time, testName[curTest], keyName, key);
			testErrors++;
		end
		if (nextEvent < lastEvent) begin
			checkCount++;
			assert (isStore == expIsStore[nextEvent]) else begin
				$display("%0t ns: test %s expected a %s but the core made a %s",
					$time, testName[curTest], expIsStore[nextEvent] ? "store" : "writeback",
					isStore ? "store" : "writeback");
				testErrors++;
			end
			assert (key == expKey[nextEvent]) else begin
				$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
					$time, keyName, expKey[nextEvent], key);
				testErrors++;
			end
			assert (value == expValue[nextEvent]) else begin
				$display("CHECK FAILED time=%0t signal=%s expected=%08h actual=%08h",
					$time, valueName, expValue[nextEvent], value);
				testErrors++;
			end
			nextEvent++;
		end
	endtask

	task automatic runTest(input int t);
		int i;
		curTest = t;
		testErrors = 0;
		nextEvent = eventFirst[t];
		lastEvent = eventFirst[t] + eventLen[t];
		wait (!reset);
		@(posedge clk);
		#2;
		// Fill instruction memory with the core idle
		for (i = 0; i < progLen[t]; i++) begin
			progWrite = 1'b1;
			progAddr = i;
			progData = progWords[progFirst[t] + i];
			@(posedge clk);
			#2;
		end
		progWrite = 1'b0;
		checking = 1'b1;
		run = 1'b1;
		wait (nextEvent == lastEvent);
		// Program spins on its last J, nothing more may retire
		repeat (quietCycles) @(posedge clk);
		#2;
		checking = 1'b0;
		run = 1'b0;
		tbReset = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		tbReset = 1'b0;
		$display("Test %s done: %0d events, %0d errors", testName[t], eventLen[t], testErrors);
		totalErrors += testErrors;
		if (testErrors != 0) begin
			failedTests++;
		end
	endtask

	always @(negedge clk) begin
		if (checking && wbValid) begin
			compareEvent(1'b0, int'(wbReg), wbData);
		end
		if (checking && storeValid) begin
			compareEvent(1'b1, int'(storeAddr), storeData);
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles: test %s still waiting for event %0d of %0d",
				cycleCount, testName[curTest], nextEvent - eventFirst[curTest] + 1,
				eventLen[curTest]);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		run = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		tbReset = 1'b0;
		checking = 1'b0;
		curTest = 0;
		nextEvent = 0;
		lastEvent = 0;
		testErrors = 0;
		totalErrors = 0;
		failedTests = 0;
		checkCount = 0;
		cycleCount = 0;
		cycleLimit = 0;
		if (!loadTable()) begin
			$display("Could not read any test from testbench/program_input.txt");
			$display("Verification failed");
			$finish;
		end else begin
			cycleLimit = 4 * progWords.size() + 50 * testName.size();
			for (int t = 0; t < testName.size(); t++) begin
				runTest(t);
			end
			totalErrors += dut.props.violations;
			$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d, assertion errors: %0d",
				testName.size(), failedTests, checkCount, totalErrors, dut.props.violations);
			if (totalErrors == 0) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
			$finish;
		end
	end

endmodule

//--- project.f
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTop_properties.sv
testbench/cpuTb.sv

//--- testbench/program_input.txt
# Per test: "test <name>", then "prog" and hex instruction words from address 0, then the
# expected events in order, "wb <reg> <hex value>" or "store <hex addr> <hex value>", then "end"

test alu_chain
# li r1,5  li r2,3  add r3,r1,r2  sub r4,r3,r1  slt r5,r4,r3  slt r6,r3,r4
# li r7,-1  slt r8,r7,r1  slt r9,r1,r7  j 9
prog 24010005 24020003 00221820 00612022 0083282a 0064302a
prog 2407ffff 00e1402a 0027482a 08000009
wb 1 00000005  wb 2 00000003  wb 3 00000008
wb 4 00000003  wb 5 00000001  wb 6 00000000
wb 7 ffffffff  wb 8 00000000  wb 9 00000001
end

test xori_r0
# li r1,0x1234  xori r2,r1,0xff00  li r0,0x7777  add r0,r1,r2
# add r3,r0,r1  xori r4,r0,0xff  nop  j 7
prog 24011234 3822ff00 24007777 00220020 00011820 380400ff 00000000 08000007
wb 1 00001234  wb 2 ffffed34
wb 3 00001234  wb 4 000000ff
end

test store_load
# li r1,0x10  li r2,0xab  sw r2,4(r1)  lw r3,4(r1)  add r4,r3,r2  sw r4,5(r1)  j 6
prog 24010010 240200ab ac220004 8c230004 00622020 ac240005 08000006
wb 1 00000010  wb 2 000000ab  store 14 000000ab
wb 3 000000ab  wb 4 00000156  store 15 00000156
end

test branch_not_taken
# li r1,7  li r2,7  bne r1,r2,+2  li r3,0x11  li r4,0x22  li r5,0x33  j 6
prog 24010007 24020007 14220002 24030011 24040022 24050033 08000006
wb 1 00000007  wb 2 00000007  wb 3 00000011
wb 4 00000022  wb 5 00000033
end

test branch_taken
# li r1,1  li r2,2  bne r1,r2,+2  li r3,0x99  li r4,0x98  li r5,0x55  add r6,r5,r1  j 7
prog 24010001 24020002 14220002 24030099 24040098 24050055 00a13020 08000007
wb 1 00000001  wb 2 00000002
wb 5 00000055  wb 6 00000056
end

test jump
# li r1,0x40  j 3  li r2,0x66  li r3,0x77  add r4,r1,r3  j 5
prog 24010040 08000003 24020066 24030077 00232020 08000005
wb 1 00000040  wb 3 00000077  wb 4 000000b7
end
